// File: Makefile
# Verilator build and run for the transmit protocol stage

VERILATOR  ?= verilator
TOP        ?= tb_etx
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS   ?= +verilator+error+limit+1000
FAIL_MSG   ?= SOME TESTS FAILED
PASS_MSG   ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: emesh_pkg.sv
package emesh_pkg;

  //####################################################################
  //# Mesh packet format
  //####################################################################

  localparam int ADDR_W     = 32;        // Dst/src address width
  localparam int DATA_W     = 32;        // Single data word
  localparam int DATAMODE_W = 2;         // Transfer size code
  localparam int CTRLMODE_W = 4;
  localparam int PKT_W      = 104;       // Full packet

  // Field offsets inside the packet
  localparam int WRITE_LSB    = 0;
  localparam int DATAMODE_LSB = 1;       // Bits 2..1
  localparam int CTRLMODE_LSB = 3;       // Bits 6..3
  localparam int DSTADDR_LSB  = 8;       // Bits 39..8
  localparam int DATA_LSB     = 40;      // Bits 71..40
  localparam int SRCADDR_LSB  = 72;      // Bits 103..72

  typedef logic [PKT_W-1:0]      pkt_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [DATAMODE_W-1:0] datamode_t;
  typedef logic [CTRLMODE_W-1:0] ctrlmode_t;

  //####################################################################
  //# Field extraction
  //####################################################################

  // Write flag, low for reads
  function automatic logic pkt_write(pkt_t pkt);
    return pkt[WRITE_LSB];
  endfunction

  function automatic datamode_t pkt_datamode(pkt_t pkt);
    return pkt[DATAMODE_LSB +: DATAMODE_W];
  endfunction

  function automatic ctrlmode_t pkt_ctrlmode(pkt_t pkt);
    return pkt[CTRLMODE_LSB +: CTRLMODE_W];
  endfunction

  // Destination address, top bits carry the node ID
  function automatic addr_t pkt_dstaddr(pkt_t pkt);
    return pkt[DSTADDR_LSB +: ADDR_W];
  endfunction

endpackage

// File: etx_burst_detect.sv
`timescale 1ns/1ps

module etx_burst_detect #(
  parameter int PW = 104,
  parameter int AW = 32
) (
  input  emesh_pkg::pkt_t new_packet,    // Packet offered this cycle
  input  emesh_pkg::pkt_t last_packet,   // Packet last registered toward IO
  output logic            burst_match
);
  import emesh_pkg::*;
  import etx_pkg::*;

  //####################################################################
  //# Field decode
  //####################################################################

  // New packet
  logic          new_write;
  datamode_t     new_datamode;
  ctrlmode_t     new_ctrlmode;
  logic [AW-1:0] new_dstaddr;

  // Last packet
  logic          last_write;
  datamode_t     last_datamode;
  ctrlmode_t     last_ctrlmode;
  logic [AW-1:0] last_dstaddr;

  // Match terms
  logic [AW-1:0] burst_addr;
  logic          double_write;
  logic          type_match;
  logic          addr_match;

  assign new_write    = pkt_write(new_packet[PW-1:0]);
  assign new_datamode = pkt_datamode(new_packet[PW-1:0]);
  assign new_ctrlmode = pkt_ctrlmode(new_packet[PW-1:0]);
  assign new_dstaddr  = pkt_dstaddr(new_packet[PW-1:0]);

  assign last_write    = pkt_write(last_packet[PW-1:0]);
  assign last_datamode = pkt_datamode(last_packet[PW-1:0]);
  assign last_ctrlmode = pkt_ctrlmode(last_packet[PW-1:0]);
  assign last_dstaddr  = pkt_dstaddr(last_packet[PW-1:0]);

  //####################################################################
  //# Burst rule
  //####################################################################

  // Only 64 bit writes can continue a burst
  assign double_write = new_write & (new_datamode == DM_DOUBLE);

  // Same write, size and control as the previous beat
  assign type_match = ({new_ctrlmode, new_datamode, new_write} ==
                       {last_ctrlmode, last_datamode, last_write});

  // Next beat sits one double word above the last one
  assign burst_addr = last_dstaddr + AW'(BURST_STRIDE);
  assign addr_match = (new_dstaddr == burst_addr);

  assign burst_match = double_write & type_match & addr_match;

endmodule

// File: etx_pkg.sv
package etx_pkg;

  //####################################################################
  //# Transmit protocol constants
  //####################################################################

  // Data-mode codes, match emesh datamode field
  localparam logic [1:0] DM_BYTE   = 2'd0;   // 8 bit
  localparam logic [1:0] DM_HALF   = 2'd1;   // 16 bit
  localparam logic [1:0] DM_WORD   = 2'd2;   // 32 bit
  localparam logic [1:0] DM_DOUBLE = 2'd3;   // 64 bit, only size that bursts

  // Address step from one burst beat to the next
  localparam int unsigned BURST_STRIDE = 8;

  // Flops per asynchronous wait input
  localparam int SYNC_STAGES = 2;

  // Node ID sits in the top bits of the destination address
  localparam int NODE_ID_W = 12;

  typedef logic [NODE_ID_W-1:0] node_id_t;

endpackage

// File: etx_protocol.sv
`timescale 1ns/1ps

module etx_protocol #(
  parameter int                PW = 104,
  parameter etx_pkg::node_id_t ID = 12'h000        // This node, never sent out
) (
  input  logic            clk,
  input  logic            reset,

  // System side
  input  logic            etx_access,
  input  emesh_pkg::pkt_t etx_packet,

  // Transmit controls
  input  logic            tx_enable,               // Static enable
  input  logic            tx_io_wait,              // Serializer busy

  // Far-end waits, already synced
  input  logic            rd_wait_sync,
  input  logic            wr_wait_sync,

  // From burst detector
  input  logic            burst_match,

  // IO side
  output emesh_pkg::pkt_t tx_packet,
  output logic            tx_access,
  output logic            tx_burst,

  // Pushback to system side
  output logic            etx_rd_wait,
  output logic            etx_wr_wait
);
  import emesh_pkg::*;
  import etx_pkg::*;

  //####################################################################
  //# Valid condition
  //####################################################################

  logic     etx_write;
  addr_t    etx_dstaddr;
  node_id_t etx_dst_id;                            // Target node of packet
  logic     id_hit;
  logic     dir_wait;
  logic     etx_valid;

  assign etx_write   = pkt_write(etx_packet);
  assign etx_dstaddr = pkt_dstaddr(etx_packet);
  assign etx_dst_id  = etx_dstaddr[ADDR_W-1 -: NODE_ID_W];

  // Addressed to ourselves, drop it
  assign id_hit = (etx_dst_id == ID);

  // Wait that applies to this packet's direction
  assign dir_wait = etx_write ? wr_wait_sync : rd_wait_sync;

  assign etx_valid = tx_enable & etx_access & ~id_hit & ~dir_wait;

  //####################################################################
  //# Output registers
  //####################################################################

  // Packet and access freeze while the serializer is busy
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_packet <= {PW{1'b0}};
      tx_access <= 1'b0;
    end
    else if (!tx_io_wait)
    begin
      tx_packet <= etx_packet;                     // Payload moves even if dropped
      tx_access <= etx_valid;
    end
  end

  // Burst flag tracks every cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_burst <= 1'b0;
    end
    else
    begin
      tx_burst <= burst_match;
    end
  end

  //####################################################################
  //# Pushback
  //####################################################################

  // Zero latency, stalls the whole system side pipeline
  assign etx_rd_wait = rd_wait_sync | tx_io_wait;
  assign etx_wr_wait = wr_wait_sync | tx_io_wait;

endmodule

// File: etx_top.sv
`timescale 1ns/1ps

module etx_top #(
  parameter int                PW = 104,           // Packet width
  parameter int                AW = 32,            // Address width
  parameter int                DW = 32,            // Data width
  parameter etx_pkg::node_id_t ID = 12'h000        // Local node ID
) (
  input  logic            clk,
  input  logic            reset,

  // System side
  input  logic            etx_access,
  input  emesh_pkg::pkt_t etx_packet,
  output logic            etx_rd_wait,
  output logic            etx_wr_wait,

  // IO side
  input  logic            tx_enable,
  output emesh_pkg::pkt_t tx_packet,
  output logic            tx_access,
  output logic            tx_burst,
  input  logic            tx_io_wait,
  input  logic            tx_rd_wait,              // Async from far end
  input  logic            tx_wr_wait               // Async from far end
);
  import emesh_pkg::*;

  // Parameters must agree with the packet format
  if ((PW != PKT_W) || (AW != ADDR_W) || (DW != DATA_W))
  begin : g_width_check
    $error("etx_top: PW/AW/DW do not match the mesh packet format");
  end

  logic rd_wait_sync;                              // Far-end waits, clk domain
  logic wr_wait_sync;
  logic burst_match;                               // New packet continues burst

  //####################################################################
  //# Blocks
  //####################################################################

  etx_wait_sync u_wait_sync (
    .clk           (clk),
    .reset         (reset),
    .rd_wait_async (tx_rd_wait),
    .wr_wait_async (tx_wr_wait),
    .rd_wait_sync  (rd_wait_sync),
    .wr_wait_sync  (wr_wait_sync)
  );

  // Compares offered packet against last registered one
  etx_burst_detect #(
    .PW (PW),
    .AW (AW)
  ) u_burst (
    .new_packet  (etx_packet),
    .last_packet (tx_packet),
    .burst_match (burst_match)
  );

  etx_protocol #(
    .PW (PW),
    .ID (ID)
  ) u_protocol (
    .clk          (clk),
    .reset        (reset),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet),
    .tx_enable    (tx_enable),
    .tx_io_wait   (tx_io_wait),
    .rd_wait_sync (rd_wait_sync),
    .wr_wait_sync (wr_wait_sync),
    .burst_match  (burst_match),
    .tx_packet    (tx_packet),
    .tx_access    (tx_access),
    .tx_burst     (tx_burst),
    .etx_rd_wait  (etx_rd_wait),
    .etx_wr_wait  (etx_wr_wait)
  );

endmodule

// File: etx_wait_sync.sv
`timescale 1ns/1ps

module etx_wait_sync (
  input  logic clk,
  input  logic reset,
  input  logic rd_wait_async,     // From far end, no clock relation
  input  logic wr_wait_async,
  output logic rd_wait_sync,
  output logic wr_wait_sync
);
  import etx_pkg::*;

  //####################################################################
  //# Synchronizer chain
  //####################################################################

  // Both waits share one chain, bit 1 read, bit 0 write
  logic [1:0] wait_async;
  logic [1:0] sync_q [SYNC_STAGES];

  assign wait_async = {rd_wait_async, wr_wait_async};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < SYNC_STAGES; i++)
      begin
        sync_q[i] <= 2'b00;               // No wait after reset
      end
    end
    else
    begin
      sync_q[0] <= wait_async;            // First stage may go metastable
      for (int i = 1; i < SYNC_STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is safe to use in the clock domain
  assign rd_wait_sync = sync_q[SYNC_STAGES-1][1];
  assign wr_wait_sync = sync_q[SYNC_STAGES-1][0];

endmodule

// File: sim.f
emesh_pkg.sv
etx_pkg.sv
etx_wait_sync.sv
etx_burst_detect.sv
etx_protocol.sv
etx_top.sv
tb_etx_asserts.sv
tb_etx_checker.sv
tb_etx.sv

// File: tb_etx.sv
`timescale 1ns/1ps

module tb_etx;
  import emesh_pkg::*;
  import etx_pkg::*;

  localparam node_id_t    LOCAL_ID  = 12'h0A5;
  localparam addr_t       SRC_ADDR  = {LOCAL_ID, 20'h0_0000};
  localparam int unsigned RAND_SEED = 32'h86d9_99f5;

  typedef struct packed {
    logic      access;
    logic      write;
    datamode_t datamode;
    ctrlmode_t ctrlmode;
    addr_t     dstaddr;
    logic      enable;
    logic      io_wait;
    logic      rd_wait;
    logic      wr_wait;
  } row_t;

  logic clk;
  logic reset;
  logic etx_access;
  pkt_t etx_packet;
  logic etx_rd_wait, etx_wr_wait;
  logic tx_enable;
  pkt_t tx_packet;
  logic tx_access, tx_burst;
  logic tx_io_wait, tx_rd_wait, tx_wr_wait;
  int   check_count, error_count;
  int   cycle_count = 0;
  row_t table_q[$];                                // Stimulus rows, one per cycle

  etx_top #(
    .PW (PKT_W),
    .AW (ADDR_W),
    .DW (DATA_W),
    .ID (LOCAL_ID)
  ) i_dut (
    .clk (clk), .reset (reset),
    .etx_access (etx_access), .etx_packet (etx_packet),
    .etx_rd_wait (etx_rd_wait), .etx_wr_wait (etx_wr_wait),
    .tx_enable (tx_enable), .tx_packet (tx_packet),
    .tx_access (tx_access), .tx_burst (tx_burst),
    .tx_io_wait (tx_io_wait), .tx_rd_wait (tx_rd_wait), .tx_wr_wait (tx_wr_wait)
  );

  tb_etx_checker #(.ID (LOCAL_ID)) i_checker (
    .clk (clk), .reset (reset),
    .etx_access (etx_access), .etx_packet (etx_packet),
    .tx_enable (tx_enable), .tx_io_wait (tx_io_wait),
    .tx_rd_wait (tx_rd_wait), .tx_wr_wait (tx_wr_wait),
    .tx_packet (tx_packet), .tx_access (tx_access), .tx_burst (tx_burst),
    .etx_rd_wait (etx_rd_wait), .etx_wr_wait (etx_wr_wait),
    .check_count (check_count), .error_count (error_count)
  );

  bind etx_protocol tb_etx_asserts u_asserts (
    .clk (clk), .reset (reset), .tx_io_wait (tx_io_wait),
    .tx_packet (tx_packet), .tx_access (tx_access), .tx_burst (tx_burst)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;                        // 100 ns period
  end

  task automatic add_row(logic access, logic write, datamode_t dm, ctrlmode_t cm,
                         addr_t dst, logic enable, logic io_wait, logic rd_wait,
                         logic wr_wait);
    row_t row;
    row = {access, write, dm, cm, dst, enable, io_wait, rd_wait, wr_wait};
    table_q.push_back(row);
  endtask

  task automatic apply_row(row_t row);
    data_t data_word;
    data_word  = $urandom();
    etx_access = row.access;
    // srcaddr, data, dstaddr, spare bit 7, ctrlmode, datamode, write
    etx_packet = {SRC_ADDR, data_word, row.dstaddr, 1'b0, row.ctrlmode, row.datamode,
                  row.write};
    tx_enable  = row.enable;
    tx_io_wait = row.io_wait;
    tx_rd_wait = row.rd_wait;
    tx_wr_wait = row.wr_wait;
  endtask

  task automatic drive_idle();
    etx_access = 1'b0;
    etx_packet = '0;
    tx_enable  = 1'b1;
    {tx_io_wait, tx_rd_wait, tx_wr_wait} = 3'b000;
  endtask

  //####################################################################
  //# Stimulus table
  //####################################################################

  task automatic build_table();
    // Plain forwarding, then access low
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0000, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0004, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b0, 1'b1, DM_WORD, 4'h0, 32'h1230_0008, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_BYTE, 4'h1, 32'h1230_0010, 1'b1, 1'b0, 1'b0, 1'b0);
    // Local node ID, then enable low
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h0A50_0000, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h0A50_0100, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0020, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0024, 1'b0, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0028, 1'b1, 1'b0, 1'b0, 1'b0);
    // Write wait, blocks writes after sync lag
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0030, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0034, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0038, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_003C, 1'b1, 1'b0, 1'b0, 1'b1);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0040, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0044, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0048, 1'b1, 1'b0, 1'b0, 1'b0);
    // Read wait, writes still pass
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0050, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0054, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0058, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_005C, 1'b1, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0060, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0064, 1'b1, 1'b0, 1'b0, 1'b0);
    // Serializer busy
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0070, 1'b1, 1'b1, 1'b0, 1'b0);
    add_row(1'b1, 1'b0, DM_WORD, 4'h0, 32'h1230_0074, 1'b1, 1'b1, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h0, 32'h1230_0078, 1'b1, 1'b0, 1'b0, 1'b0);
    // Burst runs and the cases that break them
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0100, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0108, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0110, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0118, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_011C, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0124, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_WORD, 4'h5, 32'h1230_012C, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0134, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_013C, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b0, DM_DOUBLE, 4'h5, 32'h1230_0144, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_014C, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h5, 32'h1230_0154, 1'b1, 1'b0, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h6, 32'h1230_015C, 1'b1, 1'b0, 1'b0, 1'b0);
    // Burst seen under io wait, next beat compares to held packet
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h6, 32'h1230_0164, 1'b1, 1'b1, 1'b0, 1'b0);
    add_row(1'b1, 1'b1, DM_DOUBLE, 4'h6, 32'h1230_016C, 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  //####################################################################
  //# Run control
  //####################################################################

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 10 + table_q.size() + 20)
    begin
      $display("timeout: run still going after %0d cycles", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial
  begin
    int total_errors;
    void'($urandom(RAND_SEED));
    build_table();
    reset = 1'b1;
    drive_idle();
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (table_q[i])
    begin
      apply_row(table_q[i]);
      @(posedge clk);
      #1;                                          // Drive just after the edge
    end
    drive_idle();
    repeat (3) @(posedge clk);                     // Sync lag plus output register
    @(negedge clk);
    #1;
    total_errors = error_count + i_dut.u_protocol.u_asserts.assert_fails;
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             check_count, error_count, i_dut.u_protocol.u_asserts.assert_fails);
    if (total_errors == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: tb_etx_asserts.sv
`timescale 1ns/1ps

module tb_etx_asserts (
  input  logic            clk,
  input  logic            reset,
  input  logic            tx_io_wait,
  input  emesh_pkg::pkt_t tx_packet,
  input  logic            tx_access,
  input  logic            tx_burst
);
  import etx_pkg::*;

  int assert_fails = 0;                     // Failed assertion count

  //####################################################################
  //# Protocol block properties
  //####################################################################

  // Access register comes out of reset cleared
  access_after_reset: assert property (@(posedge clk) reset |=> !tx_access)
    else
    begin
      $error("tx_access high in the cycle after reset");
      assert_fails++;
    end

  // Serializer busy freezes the packet
  packet_hold: assert property (@(posedge clk) disable iff (reset)
    tx_io_wait |=> $stable(tx_packet))
    else
    begin
      $error("tx_packet changed while tx_io_wait was high");
      assert_fails++;
    end

  // Only 64 bit writes can be flagged as burst
  burst_is_double_write: assert property (@(posedge clk) disable iff (reset)
    tx_burst |-> (tx_packet[0] && (tx_packet[2:1] == DM_DOUBLE)))
    else
    begin
      $error("tx_burst high on a packet that is not a double write");
      assert_fails++;
    end

endmodule

// File: tb_etx_checker.sv
`timescale 1ns/1ps

module tb_etx_checker #(
  parameter etx_pkg::node_id_t ID = 12'h000        // Node ID of the DUT
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            etx_access,
  input  emesh_pkg::pkt_t etx_packet,
  input  logic            tx_enable,
  input  logic            tx_io_wait,
  input  logic            tx_rd_wait,
  input  logic            tx_wr_wait,
  input  emesh_pkg::pkt_t tx_packet,
  input  logic            tx_access,
  input  logic            tx_burst,
  input  logic            etx_rd_wait,
  input  logic            etx_wr_wait,
  output int              check_count,
  output int              error_count
);
  import emesh_pkg::*;
  import etx_pkg::*;

  int   checks = 0;
  int   errors = 0;
  logic rd_q1, rd_q2;                              // Own 2 stage wait copies
  logic wr_q1, wr_q2;
  pkt_t exp_packet;                                // Last registered packet
  logic exp_access;
  logic exp_burst;
  logic in_write;
  addr_t in_addr;
  logic blocked;
  logic access_next;
  logic burst_next;

  assign check_count = checks;
  assign error_count = errors;

  //####################################################################
  //# Reference model
  //####################################################################

  always_comb
  begin
    in_write    = etx_packet[0];
    in_addr     = etx_packet[39:8];
    blocked     = in_write ? wr_q2 : rd_q2;        // Wait of this direction
    access_next = tx_enable & etx_access & (in_addr[31:20] != ID) & ~blocked;
    // Bits 6..0 hold write, datamode and ctrlmode
    burst_next  = in_write && (etx_packet[2:1] == DM_DOUBLE) &&
                  (etx_packet[6:0] == exp_packet[6:0]) &&
                  (in_addr == exp_packet[39:8] + BURST_STRIDE);
  end

  always @(posedge clk)
  begin
    if (reset)
    begin
      {rd_q1, rd_q2, wr_q1, wr_q2} <= 4'b0000;
      exp_packet <= '0;
      exp_access <= 1'b0;
      exp_burst  <= 1'b0;
    end
    else
    begin
      rd_q1 <= tx_rd_wait;
      rd_q2 <= rd_q1;
      wr_q1 <= tx_wr_wait;
      wr_q2 <= wr_q1;
      exp_burst <= burst_next;                     // Not gated by io wait
      if (!tx_io_wait)
      begin
        exp_packet <= etx_packet;
        exp_access <= access_next;
      end
    end
  end

  //####################################################################
  //# Compare, mid cycle
  //####################################################################

  task automatic check_bit(string name, logic expected, logic actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_packet(pkt_t expected, pkt_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("mismatch tx_packet expected %h actual %h at %0t", expected, actual, $time);
    end
  endtask

  always @(negedge clk)
  begin
    check_packet(exp_packet, tx_packet);
    check_bit("tx_access", exp_access, tx_access);
    check_bit("tx_burst", exp_burst, tx_burst);
    check_bit("etx_rd_wait", rd_q2 | tx_io_wait, etx_rd_wait);   // Zero latency OR
    check_bit("etx_wr_wait", wr_q2 | tx_io_wait, etx_wr_wait);
  end

endmodule
